/* Bender.yml */
package:
  name: manycore_io

sources:
  - logic/manycore_io_pkg.sv
  - logic/link_fifo.sv
  - logic/io_reset_seq.sv
  - logic/io_router_node.sv
  - logic/column_test_mem.sv
  - logic/manycore_io_top.sv
  - target: test
    files:
      - tests/manycore_io_chk.sv
      - tests/tb_manycore_io.sv

/* logic/column_test_mem.sv */
// per-column word memory serving loads and stores
`timescale 1ns/1ps
`default_nettype none

module column_test_mem
  import manycore_io_pkg::*;
#(
  parameter int COL = 0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  io_req_s  req_i,
  output logic     req_credit_o,
  output io_resp_s resp_o,
  input  logic     resp_credit_i
);

  io_req_s             req_head;
  io_resp_s            resp_next;
  io_resp_s            resp_pl_q;
  logic                resp_v_q;
  logic                do_deq;
  logic [CREDIT_W-1:0] resp_cr_q;
  logic [DATA_W-1:0]   mem_q [2**ADDR_W];

  link_fifo #(.payload_t(io_req_s)) req_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .enq_i    (req_i),
    .deq_i    (do_deq),
    .head_o   (req_head),
    .credit_o (req_credit_o)
  );

  // only take a request when its response can leave
  assign do_deq = req_head.valid && (resp_cr_q != '0);

  always_comb begin
    resp_next.valid   = 1'b1;
    resp_next.src_col = COL_W'(COL);
    resp_next.tag     = req_head.tag;
    resp_next.op      = req_head.op;
    resp_next.data    = (req_head.op == OP_STORE) ? '0 : mem_q[req_head.addr];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 2**ADDR_W; i++) begin
        mem_q[i] <= '0;
      end
    end else if (do_deq && req_head.op == OP_STORE) begin
      mem_q[req_head.addr] <= req_head.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_v_q  <= 1'b0;
      resp_cr_q <= CREDIT_W'(FIFO_DEPTH);
    end else begin
      resp_v_q  <= do_deq;
      resp_cr_q <= resp_cr_q - CREDIT_W'(do_deq) + CREDIT_W'(resp_credit_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_deq) begin
      resp_pl_q <= resp_next;
    end
  end

  always_comb begin
    resp_o       = resp_pl_q;
    resp_o.valid = resp_v_q;
  end

endmodule

`default_nettype wire

/* logic/io_reset_seq.sv */
// init counter, tag_done_o and the core reset flop chain
`timescale 1ns/1ps
`default_nettype none

module io_reset_seq
  import manycore_io_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  output logic tag_done_o,
  output logic core_rst_n_o
);

  logic [$clog2(INIT_CYCLES)-1:0] cnt_q;
  logic                           done_q;
  logic [RESET_DEPTH-1:0]         chain_q;

  // done lands on the INIT_CYCLES-th edge after release
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (!done_q) begin
      cnt_q  <= cnt_q + 1'b1;
      done_q <= (cnt_q == INIT_CYCLES - 1);
    end
  end

  // core stays in reset until done has walked through the chain
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      chain_q <= '0;
    end else begin
      chain_q <= {chain_q[RESET_DEPTH-2:0], done_q};
    end
  end

  assign tag_done_o   = done_q;
  assign core_rst_n_o = chain_q[RESET_DEPTH-1];

endmodule

`default_nettype wire

/* logic/io_router_node.sv */
// one io row column with east-bound requests, west-bound responses and a local memory port
`timescale 1ns/1ps
`default_nettype none

module io_router_node
  import manycore_io_pkg::*;
#(
  parameter int COL = 0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  io_req_s  west_req_i,
  output logic     west_req_credit_o,
  output io_req_s  east_req_o,
  input  logic     east_req_credit_i,
  input  io_resp_s east_resp_i,
  output logic     east_resp_credit_o,
  output io_resp_s west_resp_o,
  input  logic     west_resp_credit_i,
  output io_req_s  mem_req_o,
  input  logic     mem_req_credit_i,
  input  io_resp_s mem_resp_i,
  output logic     mem_resp_credit_o
);

  logic     is_last;
  io_req_s  req_head;
  io_resp_s east_in;
  io_resp_s east_head;
  io_resp_s loc_head;
  io_resp_s resp_pick;
  logic     east_cr_in;
  logic     to_local;
  logic     mem_go;
  logic     east_go;
  logic     resp_go;
  logic     pick_local;

  // output registers with one payload shared by both request outputs
  io_req_s  req_pl_q;
  io_resp_s resp_pl_q;
  logic     mem_v_q;
  logic     east_v_q;
  logic     resp_v_q;
  logic     rr_q;

  // credit counters for memory [0], east requests [1] and west responses [2]
  logic [2:0]               out_send;
  logic [2:0]               out_credit;
  logic [2:0][CREDIT_W-1:0] cr_q;

  // east end of the row sees an idle link
  assign is_last    = (COL == NUM_COLS - 1);
  assign east_in    = is_last ? '0 : east_resp_i;
  assign east_cr_in = is_last ? 1'b0 : east_req_credit_i;

  link_fifo #(.payload_t(io_req_s)) req_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .enq_i    (west_req_i),
    .deq_i    (mem_go || east_go),
    .head_o   (req_head),
    .credit_o (west_req_credit_o)
  );

  link_fifo #(.payload_t(io_resp_s)) east_resp_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .enq_i    (east_in),
    .deq_i    (resp_go && !pick_local),
    .head_o   (east_head),
    .credit_o (east_resp_credit_o)
  );

  link_fifo #(.payload_t(io_resp_s)) loc_resp_fifo (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .enq_i    (mem_resp_i),
    .deq_i    (resp_go && pick_local),
    .head_o   (loc_head),
    .credit_o (mem_resp_credit_o)
  );

  assign to_local = (req_head.dst_col == COL_W'(COL));
  assign mem_go   = req_head.valid && to_local && (cr_q[0] != '0);
  assign east_go  = req_head.valid && !to_local && (cr_q[1] != '0);

  // round robin where a set rr_q lets east go first
  assign pick_local = loc_head.valid && (!east_head.valid || !rr_q);
  assign resp_go    = (loc_head.valid || east_head.valid) && (cr_q[2] != '0);
  assign resp_pick  = pick_local ? loc_head : east_head;

  assign out_send   = {resp_go, east_go, mem_go};
  assign out_credit = {west_resp_credit_i, east_cr_in, mem_req_credit_i};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_v_q  <= 1'b0;
      east_v_q <= 1'b0;
      resp_v_q <= 1'b0;
      rr_q     <= 1'b0;
      for (int i = 0; i < 3; i++) begin
        cr_q[i] <= CREDIT_W'(FIFO_DEPTH);
      end
    end else begin
      mem_v_q  <= mem_go;
      east_v_q <= east_go;
      resp_v_q <= resp_go;
      if (resp_go) begin
        rr_q <= pick_local;
      end
      for (int i = 0; i < 3; i++) begin
        cr_q[i] <= cr_q[i] - CREDIT_W'(out_send[i]) + CREDIT_W'(out_credit[i]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_go || east_go) begin
      req_pl_q <= req_head;
    end
    if (resp_go) begin
      resp_pl_q <= resp_pick;
    end
  end

  always_comb begin
    mem_req_o         = req_pl_q;
    mem_req_o.valid   = mem_v_q;
    east_req_o        = req_pl_q;
    east_req_o.valid  = east_v_q;
    west_resp_o       = resp_pl_q;
    west_resp_o.valid = resp_v_q;
  end

endmodule

`default_nettype wire

/* logic/link_fifo.sv */
// credit-returning input buffer for any payload with a valid bit
`timescale 1ns/1ps
`default_nettype none

module link_fifo
  import manycore_io_pkg::*;
#(
  parameter type payload_t = io_req_s
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t enq_i,
  input  logic     deq_i,
  output payload_t head_o,
  output logic     credit_o
);

  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
  logic [CREDIT_W-1:0]           count_q;
  logic                          not_empty;
  logic                          do_deq;

  payload_t buf_q [FIFO_DEPTH];

  assign not_empty = (count_q != '0);
  assign do_deq    = deq_i && not_empty;

  // one credit back to the sender per dequeued entry
  assign credit_o = do_deq;

  always_comb begin
    head_o       = buf_q[rd_ptr_q];
    head_o.valid = not_empty;
  end

  // sender holds credit, so a valid input always finds room
  always_ff @(posedge clk_i) begin
    if (enq_i.valid) begin
      buf_q[wr_ptr_q] <= enq_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (enq_i.valid) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_deq) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CREDIT_W'(enq_i.valid) - CREDIT_W'(do_deq);
    end
  end

endmodule

`default_nettype wire

/* logic/manycore_io_pkg.sv */
// sizes, opcode type, request and response structs of the io router row
`default_nettype none

package manycore_io_pkg;

  // row geometry
  localparam int NUM_COLS = 4;
  localparam int COL_W    = 2;

  // packet field widths
  localparam int TAG_W  = 4;
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  // link buffer depth doubles as the initial credit of every sender
  localparam int FIFO_DEPTH = 2;
  localparam int CREDIT_W   = 2;

  // reset sequencing
  localparam int INIT_CYCLES = 8;
  localparam int RESET_DEPTH = 3;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } io_op_e;

  // host to memory request of 44 bits
  typedef struct packed {
    logic              valid;
    io_op_e            op;
    logic [COL_W-1:0]  dst_col;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } io_req_s;

  // memory to host response of 40 bits
  typedef struct packed {
    logic              valid;
    logic [COL_W-1:0]  src_col;
    logic [TAG_W-1:0]  tag;
    io_op_e            op;
    logic [DATA_W-1:0] data;
  } io_resp_s;

endpackage

`default_nettype wire

/* logic/manycore_io_top.sv */
// reset sequencer, io router row, column memories and the east tie-off
`timescale 1ns/1ps
`default_nettype none

module manycore_io_top
  import manycore_io_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  output logic     tag_done_o,
  input  io_req_s  host_req_i,
  output logic     host_req_credit_o,
  output io_resp_s host_resp_o,
  input  logic     host_resp_credit_i
);

  logic core_rst_n;

  // row links where index x is the west side of node x
  io_req_s  [NUM_COLS:0]   req_link;
  logic     [NUM_COLS:0]   req_cr;
  io_resp_s [NUM_COLS:0]   resp_link;
  logic     [NUM_COLS:0]   resp_cr;

  // local links between each node and its memory
  io_req_s  [NUM_COLS-1:0] mem_req;
  logic     [NUM_COLS-1:0] mem_req_cr;
  io_resp_s [NUM_COLS-1:0] mem_resp;
  logic     [NUM_COLS-1:0] mem_resp_cr;

  io_reset_seq rst_seq (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_done_o   (tag_done_o),
    .core_rst_n_o (core_rst_n)
  );

  // host link enters at column 0
  assign req_link[0]       = host_req_i;
  assign host_req_credit_o = req_cr[0];
  assign host_resp_o       = resp_link[0];
  assign resp_cr[0]        = host_resp_credit_i;

  // idle link at the east end of the row
  assign req_cr[NUM_COLS]    = 1'b0;
  assign resp_link[NUM_COLS] = '0;

  for (genvar x = 0; x < NUM_COLS; x++) begin : g_col
    io_router_node #(.COL(x)) io_rtr (
      .clk_i              (clk_i),
      .rst_n_i            (core_rst_n),
      .west_req_i         (req_link[x]),
      .west_req_credit_o  (req_cr[x]),
      .east_req_o         (req_link[x+1]),
      .east_req_credit_i  (req_cr[x+1]),
      .east_resp_i        (resp_link[x+1]),
      .east_resp_credit_o (resp_cr[x+1]),
      .west_resp_o        (resp_link[x]),
      .west_resp_credit_i (resp_cr[x]),
      .mem_req_o          (mem_req[x]),
      .mem_req_credit_i   (mem_req_cr[x]),
      .mem_resp_i         (mem_resp[x]),
      .mem_resp_credit_o  (mem_resp_cr[x])
    );

    column_test_mem #(.COL(x)) test_mem (
      .clk_i         (clk_i),
      .rst_n_i       (core_rst_n),
      .req_i         (mem_req[x]),
      .req_credit_o  (mem_req_cr[x]),
      .resp_o        (mem_resp[x]),
      .resp_credit_i (mem_resp_cr[x])
    );
  end

endmodule

`default_nettype wire

/* tests/manycore_io_chk.sv */
// concurrent assertions on the host link and reset outputs of the io row
`timescale 1ns/1ps
`default_nettype none

module manycore_io_chk
  import manycore_io_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     tag_done_o,
  input io_req_s  host_req_i,
  input io_resp_s host_resp_o
);

  // nothing lies east of the last column
  req_dst_in_row: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      host_req_i.valid |-> (int'(host_req_i.dst_col) < NUM_COLS)
  ) else $error("host request aimed past the last column");

  // the row is still held in reset until tag programming is done
  no_resp_before_done: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      !tag_done_o |-> !host_resp_o.valid
  ) else $error("response left the row before tag_done_o");

  // once set, done stays set until the next reset
  done_stays_high: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      tag_done_o |=> tag_done_o
  ) else $error("tag_done_o fell outside reset");

endmodule

`default_nettype wire

/* tests/tb_manycore_io.sv */
// clock, reset, stimulus table, host credit model and tag scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_manycore_io
  import manycore_io_pkg::*;
;

  localparam int NUM_ROWS     = 14;
  localparam int BP_ROW       = 6;
  localparam int HOLD_CYCLES  = 40;
  localparam int WAIT_LIMIT   = 300;
  localparam int DRAIN_CYCLES = 20;

  typedef struct packed {
    io_op_e            op;
    logic [COL_W-1:0]  col;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] exp;
  } row_s;

  logic     clk_i = 1'b0;
  logic     rst_n_i;
  logic     tag_done_o;
  io_req_s  host_req_i;
  logic     host_req_credit_o;
  io_resp_s host_resp_o;
  logic     host_resp_credit_i;

  row_s rows [NUM_ROWS];
  logic pending [2**TAG_W];
  logic timed_out;
  int   req_credits;
  int   resp_owed;
  int   hold_left;
  int   sent_cnt;
  int   got_cnt;
  int   mismatch_cnt;
  int   fail_cnt;

  manycore_io_top DUT (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .tag_done_o         (tag_done_o),
    .host_req_i         (host_req_i),
    .host_req_credit_o  (host_req_credit_o),
    .host_resp_o        (host_resp_o),
    .host_resp_credit_i (host_resp_credit_i)
  );

  bind manycore_io_top manycore_io_chk chk (.*);

  always #2 clk_i = ~clk_i;

  function automatic row_s make_row(io_op_e op, int col, int addr, logic [DATA_W-1:0] data,
                                    logic [DATA_W-1:0] exp);
    row_s r;
    r.op   = op;
    r.col  = COL_W'(col);
    r.addr = ADDR_W'(addr);
    r.data = data;
    r.exp  = exp;
    return r;
  endfunction

  task automatic fill_rows();
    // loads before any store read back the cleared memory
    rows[0]  = make_row(OP_LOAD, 0, 5, '0, '0);
    rows[1]  = make_row(OP_LOAD, 1, 5, '0, '0);
    rows[2]  = make_row(OP_LOAD, 2, 5, '0, '0);
    rows[3]  = make_row(OP_LOAD, 3, 5, '0, '0);
    rows[4]  = make_row(OP_STORE, 3, 2, 32'hcafe_0003, '0);
    rows[5]  = make_row(OP_LOAD, 3, 2, '0, 32'hcafe_0003);
    // same address in every column sent under back-pressure
    rows[6]  = make_row(OP_STORE, 0, 9, 32'h1111_0000, '0);
    rows[7]  = make_row(OP_STORE, 1, 9, 32'h2222_0001, '0);
    rows[8]  = make_row(OP_STORE, 2, 9, 32'h3333_0002, '0);
    rows[9]  = make_row(OP_STORE, 3, 9, 32'h4444_0003, '0);
    rows[10] = make_row(OP_LOAD, 0, 9, '0, 32'h1111_0000);
    rows[11] = make_row(OP_LOAD, 1, 9, '0, 32'h2222_0001);
    rows[12] = make_row(OP_LOAD, 2, 9, '0, 32'h3333_0002);
    rows[13] = make_row(OP_LOAD, 3, 9, '0, 32'h4444_0003);
  endtask

  task automatic check_value(string name, logic [DATA_W-1:0] actual,
                             logic [DATA_W-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
      mismatch_cnt++;
    end
  endtask

  task automatic report_failure(string msg);
    $display("ERROR: %s", msg);
    fail_cnt++;
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic score_response(io_resp_s resp);
    int t;
    t = int'(resp.tag);
    if (!pending[t]) begin
      report_failure($sformatf("response for tag %0d with no request outstanding", t));
    end else begin
      pending[t] = 1'b0;
      got_cnt++;
      check_value("host_resp_o.src_col", resp.src_col, rows[t].col);
      check_value("host_resp_o.op", resp.op, rows[t].op);
      check_value("host_resp_o.data", resp.data, rows[t].exp);
    end
  endtask

  // wait one clock then sample the stable outputs and drive the next inputs
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    host_req_i = '0;
    if (host_req_credit_o === 1'b1) begin
      req_credits++;
      if (req_credits > FIFO_DEPTH) begin
        report_failure("DUT returned more request credits than its buffer holds");
      end
    end
    if (host_resp_o.valid === 1'b1) begin
      resp_owed++;
      if (resp_owed > FIFO_DEPTH) begin
        report_failure("DUT sent a response without holding a credit");
      end
      score_response(host_resp_o);
    end
    // random gaps in the returned credits and none at all while holding
    host_resp_credit_i = 1'b0;
    if (hold_left > 0) begin
      hold_left--;
    end else if (resp_owed > 0 && ($urandom % 3) != 0) begin
      host_resp_credit_i = 1'b1;
      resp_owed--;
    end
  endtask

  task automatic wait_req_credit();
    int t;
    t = 0;
    while (req_credits == 0 && !timed_out) begin
      if (t == WAIT_LIMIT) begin
        report_failure("timed out waiting for a host request credit");
        timed_out = 1'b1;
      end else begin
        next_cycle();
        t++;
      end
    end
  endtask

  task automatic send_request(int r);
    host_req_i.valid   = 1'b1;
    host_req_i.op      = rows[r].op;
    host_req_i.dst_col = rows[r].col;
    host_req_i.tag     = TAG_W'(r);
    host_req_i.addr    = rows[r].addr;
    host_req_i.data    = rows[r].data;
    pending[r]         = 1'b1;
    req_credits--;
    sent_cnt++;
    next_cycle();
  endtask

  task automatic wait_responses();
    int t;
    t = 0;
    while (got_cnt < sent_cnt && !timed_out) begin
      if (t == WAIT_LIMIT) begin
        report_failure("timed out waiting for outstanding responses");
        timed_out = 1'b1;
      end else begin
        next_cycle();
        t++;
      end
    end
  endtask

  initial begin
    int edges;
    void'($urandom(62));
    rst_n_i            = 1'b0;
    host_req_i         = '0;
    host_resp_credit_i = 1'b0;
    timed_out          = 1'b0;
    req_credits        = FIFO_DEPTH;
    resp_owed          = 0;
    hold_left          = 0;
    sent_cnt           = 0;
    got_cnt            = 0;
    mismatch_cnt       = 0;
    fail_cnt           = 0;
    for (int t = 0; t < 2**TAG_W; t++) begin
      pending[t] = 1'b0;
    end
    fill_rows();

    repeat (2) begin
      next_cycle();
      check_value("tag_done_o", tag_done_o, 1'b0);
    end
    rst_n_i = 1'b1;

    // count edges from release up to done
    edges = 0;
    while (tag_done_o !== 1'b1 && edges < WAIT_LIMIT) begin
      next_cycle();
      edges++;
    end
    if (tag_done_o !== 1'b1) begin
      report_failure("tag_done_o never rose after reset");
    end else begin
      check_value("tag_done_o rise cycle", edges, INIT_CYCLES);
      repeat (RESET_DEPTH + 1) next_cycle();

      for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
        if (r == BP_ROW) begin
          wait_responses();
          hold_left = HOLD_CYCLES;
        end
        wait_req_credit();
        if (!timed_out) begin
          send_request(r);
        end
      end
      wait_responses();

      // idle so a late duplicate would still be seen
      repeat (DRAIN_CYCLES) next_cycle();
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/manycore_io_pkg.sv
logic/link_fifo.sv
logic/io_reset_seq.sv
logic/io_router_node.sv
logic/column_test_mem.sv
logic/manycore_io_top.sv
tests/manycore_io_chk.sv
tests/tb_manycore_io.sv
